//--- build.f
rtl/rvCorePkg.sv
rtl/instrDecode.sv
rtl/controlUnit.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/memoryHandler.sv
rtl/rvCore.sv
verification/rvCoreTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = rvCoreTb
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verification/programInput.txt
# instr memData aluResult addrToMem dataToMem byteEnable flags(zero err ctrlErr branch memRd memWr)
# rd rdValueAfterEdge   -- text after the ninth field is a note
00500093 00000000 00000005 00000004 00000000 0 000000 1  00000005 addi x1,x0,5
FFD00113 00000000 FFFFFFFD FFFFFFFC 00000000 0 000000 2  FFFFFFFD addi x2,x0,-3
7FF00193 00000000 000007FF 000007FC 00000000 0 000000 3  000007FF addi x3,x0,0x7ff
80000237 00000000 00000000 00000000 00000000 0 100000 4  80000000 lui x4,0x80000
002082B3 00000000 00000002 00000000 FFFD0000 0 000000 5  00000002 add x5,x1,x2
40108333 00000000 00000000 00000000 00000005 0 100000 6  00000000 sub x6,x1,x1
402083B3 00000000 00000008 00000008 FFFFFFFD 0 000000 7  00000008 sub x7,x1,x2
00109433 00000000 000000A0 000000A0 00000005 0 000000 8  000000A0 sll x8,x1,x1
001124B3 00000000 00000001 00000000 00000500 0 000000 9  00000001 slt x9,x2,x1
00113533 00000000 00000000 00000000 00000005 0 100000 10 00000000 sltu x10,x2,x1
003145B3 00000000 FFFFF802 FFFFF800 07FF0000 0 000000 11 FFFFF802 xor x11,x2,x3
00115633 00000000 07FFFFFF 07FFFFFC 05000000 0 000000 12 07FFFFFF srl x12,x2,x1
401156B3 00000000 FFFFFFFF FFFFFFFC 05000000 0 000000 13 FFFFFFFF sra x13,x2,x1
0030E733 00000000 000007FF 000007FC FF000000 0 000000 14 000007FF or x14,x1,x3
003177B3 00000000 000007FD 000007FC 0007FF00 0 000000 15 000007FD and x15,x2,x3
FFF12813 00000000 00000001 00000000 00000000 0 000000 16 00000001 slti x16,x2,-1
00F0C913 00000000 0000000A 00000008 07FD0000 0 000000 18 0000000A xori x18,x1,0xf
00216993 00000000 FFFFFFFF FFFFFFFC FD000000 0 000000 19 FFFFFFFF ori x19,x2,2
0F01FA13 00000000 000000F0 000000F0 00000001 0 000000 20 000000F0 andi x20,x3,0xf0
00309A93 00000000 00000028 00000028 000007FF 0 000000 21 00000028 slli x21,x1,3
40425B13 00000000 F8000000 F8000000 80000000 0 000000 22 F8000000 srai x22,x4,4
00708013 00000000 0000000C 0000000C 00000008 0 000000 0  00000000 addi x0,x1,7
00108463 00000000 00000001 00000000 00000500 0 000100 0  00000000 beq x1,x1,8
00109463 00000000 00000000 00000000 00000005 0 100000 0  00000000 bne x1,x1,8
00114463 00000000 00000001 00000000 00000500 0 000100 0  00000000 blt x2,x1,8
00115463 00000000 00000000 00000000 00000005 0 100000 0  00000000 bge x2,x1,8
00116463 00000000 00000000 00000000 00000005 0 100000 0  00000000 bltu x2,x1,8
00117463 00000000 00000001 00000000 00000500 0 000100 0  00000000 bgeu x2,x1,8
12345C37 00000000 0000089F 0000089C FF000000 0 000000 24 12345000 lui x24,0x12345
678C0C13 00000000 12345678 12345678 12345000 0 000000 24 12345678 addi x24,x24,0x678
01800023 00000000 00000000 00000000 12345678 1 100001 0  00000000 sb x24,0(x0)
018000A3 00000000 00000001 00000000 34567800 2 000001 0  00000000 sb x24,1(x0)
01800123 00000000 00000002 00000000 56780000 4 000001 0  00000000 sb x24,2(x0)
018001A3 00000000 00000003 00000000 78000000 8 000001 0  00000000 sb x24,3(x0)
01801023 00000000 00000000 00000000 12345678 3 100001 0  00000000 sh x24,0(x0)
018010A3 00000000 00000001 00000000 34567800 6 000001 0  00000000 sh x24,1(x0)
0180A3A3 00000000 0000000C 0000000C 12345678 F 000001 0  00000000 sw x24,7(x1)
FF83AE23 00000000 00000004 00000004 12345678 F 000001 0  00000000 sw x24,-4(x7)
00000C83 80F17F8C 00000000 00000000 00000000 0 100010 25 FFFFFF8C lb x25,0(x0)
00104D03 80F17F8C 00000001 00000000 00000500 0 000010 26 0000007F lbu x26,1(x0)
00201E83 80F17F8C 00000002 00000000 FFFD0000 0 000010 29 FFFF80F1 lh x29,2(x0)
00005F03 80F17F8C 00000000 00000000 00000000 0 100010 30 00007F8C lhu x30,0(x0)
FFF0AF83 80F17F8C 00000004 00000004 00000000 0 000010 31 80F17F8C lw x31,-1(x1)
00000000 00000000 00000000 00000000 00000000 0 101000 0  00000000 zero word
008000EF 00000000 000000A0 000000A0 000000A0 0 001000 0  00000000 jal x1,8
02208033 00000000 00000002 00000000 FFFD0000 0 010000 0  00000000 op funct7 0x01

//--- verification/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb import rvCorePkg::*; ();

    localparam int clkPeriod = 40;
    localparam string stimFile = "verification/programInput.txt";

    logic            clk;
    logic            rst;
    logic [xlen-1:0] instruction;
    logic [xlen-1:0] dataFromMem;
    logic [xlen-1:0] aluResult;
    logic            zeroFlag;
    logic            errFlag;
    logic            ctrlErr;
    logic            branchTaken;
    logic [xlen-1:0] addrToMem;
    logic [xlen-1:0] dataToMem;
    logic [3:0]      byteEnable;
    logic            memRead;
    logic            memWrite;
    logic [xlen-1:0] regWindow [regCount];

    logic [xlen-1:0] expReg [regCount]; // register contents the file says we should see
    string           lines[$];          // data lines without comments
    int              lineCount = 0;
    bit              loaded = 1'b0;     // watchdog starts once lines are counted

    rvCore rvCore_i (
        .clk(clk), .rst(rst), .instruction(instruction), .dataFromMem(dataFromMem),
        .aluResult(aluResult), .zeroFlag(zeroFlag), .errFlag(errFlag),
        .ctrlErr(ctrlErr), .branchTaken(branchTaken), .addrToMem(addrToMem),
        .dataToMem(dataToMem), .byteEnable(byteEnable), .memRead(memRead),
        .memWrite(memWrite), .regWindow(regWindow)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk; // 40 ns period
    end

    task automatic abortRun();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns %s: read 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            abortRun();
        end
    endtask

    // run length follows the number of data lines
    initial begin
        wait (loaded);
        #((lineCount + 10) * clkPeriod);
        $display("timeout: no result after %0d clock cycles", lineCount + 10);
        abortRun();
    end

    initial begin
        int              fd;
        string           line;
        int              got;
        logic [xlen-1:0] instrWord;
        logic [xlen-1:0] memWord;
        logic [xlen-1:0] expAlu;
        logic [xlen-1:0] expAddr;
        logic [xlen-1:0] expDout;
        logic [3:0]      expBe;
        logic [5:0]      expFlags; // zero err ctrlErr branch memRead memWrite
        logic [4:0]      rdIdx;
        logic [xlen-1:0] expVal;

        rst         = 1'b1;
        instruction = '0; // illegal opcode keeps every enable off in reset
        dataFromMem = '0;
        for (int i = 0; i < regCount; i++) begin
            expReg[i[4:0]] = '0;
        end

        fd = $fopen(stimFile, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", stimFile);
            abortRun();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin // skip comments and blanks
                lines.push_back(line);
            end
        end
        $fclose(fd);
        lineCount = lines.size();
        loaded    = 1'b1;

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        foreach (lines[n]) begin
            got = $sscanf(lines[n], "%h %h %h %h %h %h %b %d %h", instrWord, memWord,
                          expAlu, expAddr, expDout, expBe, expFlags, rdIdx, expVal);
            if (got != 9) begin
                $display("stimulus line %0d does not hold nine fields", n + 1);
                abortRun();
            end
            instruction = instrWord; // 2 ns after the edge
            dataFromMem = memWord;

            #(clkPeriod - 3); // just before the next edge
            checkValue("aluResult", aluResult, expAlu);
            checkValue("addrToMem", addrToMem, expAddr);
            checkValue("dataToMem", dataToMem, expDout);
            checkValue("byteEnable", 32'(byteEnable), 32'(expBe));
            checkValue("flags zero,err,ctrlErr,branch,memRead,memWrite",
                       32'({zeroFlag, errFlag, ctrlErr, branchTaken, memRead, memWrite}),
                       32'(expFlags));

            @(posedge clk);
            #1;
            expReg[rdIdx] = expVal;
            for (int i = 0; i < regCount; i++) begin // every register so stray writes show up
                checkValue($sformatf("regWindow[%0d]", i), regWindow[i[4:0]], expReg[i[4:0]]);
            end
            #1;
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- rtl/rvCore.sv
`timescale 1ns/1ps

module rvCore import rvCorePkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] instruction,  // one instruction per cycle
    input  logic [xlen-1:0] dataFromMem,  // combinational memory read data
    output logic [xlen-1:0] aluResult,
    output logic            zeroFlag,
    output logic            errFlag,      // bad funct3 or funct7
    output logic            ctrlErr,      // bad opcode
    output logic            branchTaken,
    output logic [xlen-1:0] addrToMem,
    output logic [xlen-1:0] dataToMem,
    output logic [3:0]      byteEnable,
    output logic            memRead,
    output logic            memWrite,
    output logic [xlen-1:0] regWindow [regCount]
);

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm;
    regWriteSrcT     regWriteSrc;
    logic            aluSrc;
    logic            regWrite;
    logic            branch;
    logic            ctrlMemWrite; // request from control before the handler
    logic            ctrlMemRead;
    logic [xlen-1:0] regA;
    logic [xlen-1:0] regB;
    logic [xlen-1:0] memData;

    instrDecode decoder (
        .instruction(instruction), .rs1(rs1), .rs2(rs2), .rd(rd),
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .imm(imm)
    );

    controlUnit control (
        .opcode(opcode), .regWriteSrc(regWriteSrc), .aluSrc(aluSrc),
        .regWrite(regWrite), .branch(branch), .memWrite(ctrlMemWrite),
        .memRead(ctrlMemRead), .ctrlErr(ctrlErr)
    );

    alu execUnit (
        .opcode(opcode), .funct3(funct3), .funct7(funct7),
        .regA(regA), .regB(regB), .imm(imm), .aluSrc(aluSrc), .branch(branch),
        .aluResult(aluResult), .zeroFlag(zeroFlag), .errFlag(errFlag),
        .branchTaken(branchTaken)
    );

    registerFile regs (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
        .regWrite(regWrite), .regWriteSrc(regWriteSrc), .aluResult(aluResult),
        .memData(memData), .imm(imm), .regA(regA), .regB(regB),
        .regWindow(regWindow)
    );

    memoryHandler memHandler (
        .aluResult(aluResult), .regB(regB), .dataFromMem(dataFromMem),
        .funct3(funct3), .memRead(ctrlMemRead), .memWrite(ctrlMemWrite),
        .addrToMem(addrToMem), .dataToMem(dataToMem), .byteEnable(byteEnable),
        .memData(memData), .memRdOut(memRead), .memWrOut(memWrite)
    );

endmodule

//--- rtl/memoryHandler.sv
`timescale 1ns/1ps

module memoryHandler import rvCorePkg::*; (
    input  logic [xlen-1:0] aluResult,   // effective byte address
    input  logic [xlen-1:0] regB,        // store data from rs2
    input  logic [xlen-1:0] dataFromMem, // word returned by memory
    input  logic [2:0]      funct3,      // access size and sign
    input  logic            memRead,
    input  logic            memWrite,
    output logic [xlen-1:0] addrToMem,   // word aligned
    output logic [xlen-1:0] dataToMem,   // store data in its byte lane
    output logic [3:0]      byteEnable,
    output logic [xlen-1:0] memData,     // load data for write back
    output logic            memRdOut,
    output logic            memWrOut
);

    logic [1:0]      offset;    // byte within the word
    logic [4:0]      laneShift; // offset in bits
    logic [xlen-1:0] laneData;  // addressed bytes moved to the bottom

    assign offset    = aluResult[1:0];
    assign laneShift = {offset, 3'b000};
    assign addrToMem = {aluResult[xlen-1:2], 2'b00};
    assign dataToMem = regB << laneShift;
    assign laneData  = dataFromMem >> laneShift;

    always_comb begin
        byteEnable = 4'b0000;
        if (memWrite) begin
            case (funct3[1:0])
                2'b00:   byteEnable = 4'b0001 << offset; // sb
                2'b01:   byteEnable = 4'b0011 << offset; // sh
                2'b10:   byteEnable = 4'b1111;           // sw
                default: byteEnable = 4'b0000;           // no such size
            endcase
        end
    end

    always_comb begin
        memData = '0;
        if (memRead) begin
            case (funct3)
                3'b000:  memData = {{24{laneData[7]}}, laneData[7:0]};   // lb
                3'b001:  memData = {{16{laneData[15]}}, laneData[15:0]}; // lh
                3'b010:  memData = laneData;                             // lw
                3'b100:  memData = {24'b0, laneData[7:0]};               // lbu
                3'b101:  memData = {16'b0, laneData[15:0]};              // lhu
                default: memData = '0;
            endcase
        end
    end

    // memory completes in the same cycle so requests pass straight out
    assign memRdOut = memRead;
    assign memWrOut = memWrite;

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile import rvCorePkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1,        // read port a address
    input  logic [4:0]      rs2,        // read port b address
    input  logic [4:0]      rd,         // write address
    input  logic            regWrite,   // write enable from control
    input  regWriteSrcT     regWriteSrc,
    input  logic [xlen-1:0] aluResult,
    input  logic [xlen-1:0] memData,    // extended load data
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] regA,
    output logic [xlen-1:0] regB,
    output logic [xlen-1:0] regWindow [regCount] // full register view
);

    logic [xlen-1:0] regs [regCount];
    logic [xlen-1:0] writeData;

    always_comb begin
        case (regWriteSrc)
            wbMem:   writeData = memData;
            wbImm:   writeData = imm;
            default: writeData = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rd != 5'd0) begin // x0 never written
            regs[rd] <= writeData;
        end
    end

    // reads are asynchronous so the alu sees operands in the same cycle
    assign regA      = regs[rs1];
    assign regB      = regs[rs2];
    assign regWindow = regs;

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu import rvCorePkg::*; (
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [xlen-1:0] regA,        // operand a from rs1
    input  logic [xlen-1:0] regB,        // rs2 value
    input  logic [xlen-1:0] imm,         // decoded immediate
    input  logic            aluSrc,      // pick imm over regB
    input  logic            branch,      // branch instruction from control
    output logic [xlen-1:0] aluResult,
    output logic            zeroFlag,    // result is zero
    output logic            errFlag,     // undefined function encoding
    output logic            branchTaken  // branch and condition true
);

    operationT       operation;
    logic [xlen-1:0] opB;
    logic [4:0]      shamt;      // low five bits of operand b
    logic            baseFunct;  // funct7 all zero
    logic            altFunct;   // funct7 selects sub or sra
    logic            eq;
    logic            ltSigned;
    logic            ltUnsigned;

    assign opB        = aluSrc ? imm : regB;
    assign shamt      = opB[4:0];
    assign baseFunct  = (funct7 == 7'b0000000);
    assign altFunct   = (funct7 == 7'b0100000);
    assign eq         = (regA == opB);
    assign ltSigned   = ($signed(regA) < $signed(opB));
    assign ltUnsigned = (regA < opB);

    always_comb begin
        operation = aluAdd;
        errFlag   = 1'b0;
        case (opcode)
            opOp, opOpImm: begin
                case (funct3)
                    3'd0: operation = (opcode == opOp && altFunct) ? aluSub : aluAdd;
                    3'd1: operation = aluSll;
                    3'd2: operation = aluSlt;
                    3'd3: operation = aluSltu;
                    3'd4: operation = aluXor;
                    3'd5: operation = altFunct ? aluSra : aluSrl;
                    3'd6: operation = aluOr;
                    default: operation = aluAnd;
                endcase
                if (funct3 == 3'd5 || (funct3 == 3'd0 && opcode == opOp)) begin
                    errFlag = !baseFunct && !altFunct; // only two funct7 values exist here
                end else if (funct3 == 3'd1 || opcode == opOp) begin
                    errFlag = !baseFunct; // imm form funct7 bits are immediate
                end
            end
            opBranch: begin
                case (funct3)
                    3'd0: operation = aluBeq;
                    3'd1: operation = aluBne;
                    3'd4: operation = aluBlt;
                    3'd5: operation = aluBge;
                    3'd6: operation = aluBltu;
                    3'd7: operation = aluBgeu;
                    default: errFlag = 1'b1; // funct3 2 and 3 reserved
                endcase
            end
            default: operation = aluAdd; // loads, stores and address math
        endcase
    end

    always_comb begin
        case (operation)
            aluAdd:  aluResult = regA + opB;
            aluSub:  aluResult = regA - opB;
            aluSll:  aluResult = regA << shamt;
            aluSlt:  aluResult = {{(xlen-1){1'b0}}, ltSigned};
            aluSltu: aluResult = {{(xlen-1){1'b0}}, ltUnsigned};
            aluXor:  aluResult = regA ^ opB;
            aluSrl:  aluResult = regA >> shamt;
            aluSra:  aluResult = $signed(regA) >>> shamt; // sign fill
            aluOr:   aluResult = regA | opB;
            aluAnd:  aluResult = regA & opB;
            aluBeq:  aluResult = {{(xlen-1){1'b0}}, eq};
            aluBne:  aluResult = {{(xlen-1){1'b0}}, ~eq};
            aluBlt:  aluResult = {{(xlen-1){1'b0}}, ltSigned};
            aluBge:  aluResult = {{(xlen-1){1'b0}}, ~ltSigned};
            aluBltu: aluResult = {{(xlen-1){1'b0}}, ltUnsigned};
            default: aluResult = {{(xlen-1){1'b0}}, ~ltUnsigned}; // bgeu
        endcase
    end

    assign zeroFlag    = (aluResult == '0);
    assign branchTaken = branch && !errFlag && aluResult[0]; // reserved funct3 never branches

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import rvCorePkg::*; (
    input  logic [6:0]  opcode,      // major opcode from decode
    output regWriteSrcT regWriteSrc, // write back source select
    output logic        aluSrc,      // immediate as operand b
    output logic        regWrite,    // write rd at the clock edge
    output logic        branch,      // conditional branch
    output logic        memWrite,    // store request
    output logic        memRead,     // load request
    output logic        ctrlErr      // opcode outside the supported set
);

    always_comb begin
        // everything idle unless the opcode turns it on
        regWriteSrc = wbAlu;
        aluSrc      = 1'b0;
        regWrite    = 1'b0;
        branch      = 1'b0;
        memWrite    = 1'b0;
        memRead     = 1'b0;
        ctrlErr     = 1'b0;

        case (opcode)
            opLoad: begin
                regWriteSrc = wbMem;
                aluSrc      = 1'b1; // base plus offset
                regWrite    = 1'b1;
                memRead     = 1'b1;
            end
            opStore: begin
                aluSrc   = 1'b1; // base plus offset
                memWrite = 1'b1;
            end
            opOpImm: begin
                regWriteSrc = wbAlu;
                aluSrc      = 1'b1;
                regWrite    = 1'b1;
            end
            opOp: begin
                regWriteSrc = wbAlu;
                regWrite    = 1'b1;
            end
            opBranch: begin
                branch = 1'b1; // compares rs1 against rs2
            end
            opLui: begin
                regWriteSrc = wbImm; // immediate goes straight to rd
                regWrite    = 1'b1;
            end
            default: begin
                ctrlErr = 1'b1; // jal, jalr, auipc, system and zero words land here
            end
        endcase
    end

endmodule

//--- rtl/instrDecode.sv
`timescale 1ns/1ps

module instrDecode import rvCorePkg::*; (
    input  instrU             instruction, // raw instruction word
    output logic [4:0]        rs1,         // source register 1 address
    output logic [4:0]        rs2,         // source register 2 address
    output logic [4:0]        rd,          // destination register address
    output logic [6:0]        opcode,      // major opcode
    output logic [2:0]        funct3,      // minor function code
    output logic [6:0]        funct7,      // upper function code
    output logic [xlen-1:0]   imm          // sign extended immediate
);

    logic [xlen-1:0] immI; // loads and register immediate ops
    logic [xlen-1:0] immS; // stores
    logic [xlen-1:0] immB; // branch offset, bit 0 always clear
    logic [xlen-1:0] immU; // upper immediate

    // register and function fields sit at the same place in every format
    assign rs1    = instruction.rType.rs1;
    assign rs2    = instruction.rType.rs2;
    assign rd     = instruction.rType.rd;
    assign opcode = instruction.rType.opcode;
    assign funct3 = instruction.rType.funct3;
    assign funct7 = instruction.rType.funct7;

    assign immI = {
        {20{instruction.iType.imm11to0[11]}}, // sign from bit 31
        instruction.iType.imm11to0
    };

    assign immS = {
        {20{instruction.sType.imm11to5[6]}},
        instruction.sType.imm11to5, // high part above rs2
        instruction.sType.imm4to0   // low part in the rd slot
    };

    assign immB = {
        {19{instruction.bType.imm12}},
        instruction.bType.imm12,
        instruction.bType.imm11,    // taken from bit 7
        instruction.bType.imm10to5,
        instruction.bType.imm4to1,
        1'b0                        // halfword aligned target
    };

    assign immU = {instruction.uType.imm31to12, 12'b0};

    always_comb begin
        case (opcode)
            opLoad, opOpImm: begin
                imm = immI;
            end
            opStore: begin
                imm = immS;
            end
            opBranch: begin
                imm = immB;
            end
            opLui: begin
                imm = immU;
            end
            default: begin
                imm = '0; // r type and unknown opcodes carry no immediate
            end
        endcase
    end

endmodule

//--- rtl/rvCorePkg.sv
package rvCorePkg;

    localparam int xlen     = 32; // data word width
    localparam int regCount = 32; // architectural integer registers

    // major opcodes handled by the datapath
    localparam logic [6:0] opLoad   = 7'b0000011; // lb lh lw lbu lhu
    localparam logic [6:0] opStore  = 7'b0100011; // sb sh sw
    localparam logic [6:0] opOpImm  = 7'b0010011; // register immediate arithmetic
    localparam logic [6:0] opOp     = 7'b0110011; // register register arithmetic
    localparam logic [6:0] opBranch = 7'b1100011; // conditional branches
    localparam logic [6:0] opLui    = 7'b0110111; // load upper immediate

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9,
        aluBeq  = 4'd10, // compare ops return 1 when the condition holds
        aluBne  = 4'd11,
        aluBlt  = 4'd12,
        aluBge  = 4'd13,
        aluBltu = 4'd14,
        aluBgeu = 4'd15
    } operationT;

    typedef enum logic [1:0] {
        wbAlu = 2'd0, // alu result
        wbMem = 2'd1, // extended load data
        wbImm = 2'd2  // immediate, used by lui
    } regWriteSrcT;

    // one instruction word seen in each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm11to0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] imm11to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4to0;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm31to12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uType;
    } instrU;

endpackage
